//--- source/flash_pkg.sv
`default_nettype none

package flash_pkg;

    // Bus widths with a meaning of their own
    typedef logic [7:0]  spi_byte_t;    // One byte on the wire
    typedef logic [23:0] flash_addr_t;  // Flash byte address
    typedef logic [7:0]  sector_t;      // 64 KiB sector number
    typedef logic [5:0]  frame_bits_t;  // Bits in one frame, 0 to 32
    typedef logic [31:0] frame_word_t;  // Transmit word, MSB goes out first

    // Command opcodes
    localparam spi_byte_t CMD_WREN = 8'h06;  // Write Enable
    localparam spi_byte_t CMD_SE   = 8'hD8;  // Sector Erase
    localparam spi_byte_t CMD_RDSR = 8'h05;  // Read Status Register

    // Sector number to byte address
    localparam int unsigned SECTOR_SHIFT = 16;

    // Write in progress flag in the status byte
    localparam int unsigned WIP_BIT = 0;

    // Frame lengths in bits
    localparam frame_bits_t BITS_WREN = 6'd8;   // Opcode only
    localparam frame_bits_t BITS_SE   = 6'd32;  // Opcode and 24-bit address
    localparam frame_bits_t BITS_RDSR = 6'd16;  // Opcode and one status byte

endpackage

`default_nettype wire

//--- source/erase_request_capture.sv
`default_nettype none

module erase_request_capture (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic                    erase_start,
    input  flash_pkg::sector_t      sector,
    input  logic                    finish,
    output logic                    busy,
    output logic                    req,
    output flash_pkg::flash_addr_t  req_addr
);

    logic accept;

    // A strobe counts only while no erase is running
    assign accept = erase_start && !busy;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            busy <= 1'b0;
            req  <= 1'b0;
        end else begin
            req <= accept;
            if (finish) begin
                busy <= 1'b0;   // Falls the cycle after done or fail
            end else if (accept) begin
                busy <= 1'b1;
            end
        end
    end

    // Held for the whole erase, later strobes cannot touch it
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            req_addr <= flash_pkg::flash_addr_t'(sector) << flash_pkg::SECTOR_SHIFT;
        end
    end

endmodule

`default_nettype wire

//--- source/erase_sequencer.sv
`default_nettype none

module erase_sequencer #(
    parameter int HALF_CYCLES = 5,
    parameter int MAX_POLLS   = 200
) (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic                    req,
    input  flash_pkg::flash_addr_t  req_addr,
    input  logic                    frame_done,
    input  flash_pkg::spi_byte_t    rx_byte,
    output logic                    frame_start,
    output flash_pkg::frame_word_t  frame_word,
    output flash_pkg::frame_bits_t  frame_bits,
    output logic                    finish,
    output logic                    erase_done,
    output logic                    erase_fail
);

    localparam int GAP_W  = $clog2(2 * HALF_CYCLES + 1);
    localparam int POLL_W = $clog2(MAX_POLLS + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SEND_WREN,
        S_SEND_SE,
        S_SEND_RDSR,
        S_CHECK_STATUS,
        S_GAP
    } state_t;

    state_t             state;
    state_t             after_gap;      // Frame to send once the gap ends
    state_t             next_send;
    logic [GAP_W-1:0]   gap_cnt;
    logic [POLL_W-1:0]  poll_cnt;
    logic               gap_last;
    logic               frame_launch;
    logic               wip;

    function automatic flash_pkg::frame_word_t word_for(input state_t s,
                                                        input flash_pkg::flash_addr_t addr);
        flash_pkg::frame_word_t w;
        case (s)
            S_SEND_WREN: w = {flash_pkg::CMD_WREN, 24'h000000};
            S_SEND_SE:   w = {flash_pkg::CMD_SE, addr};
            default:     w = {flash_pkg::CMD_RDSR, 24'h000000};  // Dummy byte out
        endcase
        return w;
    endfunction

    function automatic flash_pkg::frame_bits_t bits_for(input state_t s);
        flash_pkg::frame_bits_t b;
        case (s)
            S_SEND_WREN: b = flash_pkg::BITS_WREN;
            S_SEND_SE:   b = flash_pkg::BITS_SE;
            default:     b = flash_pkg::BITS_RDSR;
        endcase
        return b;
    endfunction

    assign gap_last     = (gap_cnt == GAP_W'(2 * HALF_CYCLES - 1));
    assign frame_launch = ((state == S_IDLE) && req) || ((state == S_GAP) && gap_last);
    assign next_send    = (state == S_IDLE) ? S_SEND_WREN : after_gap;
    assign wip          = rx_byte[flash_pkg::WIP_BIT];

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state       <= S_IDLE;
            after_gap   <= S_SEND_WREN;
            gap_cnt     <= '0;
            poll_cnt    <= '0;
            frame_start <= 1'b0;
            finish      <= 1'b0;
            erase_done  <= 1'b0;
            erase_fail  <= 1'b0;
        end else begin
            frame_start <= frame_launch;
            finish      <= 1'b0;
            erase_done  <= 1'b0;
            erase_fail  <= 1'b0;
            case (state)
                S_IDLE: begin
                    poll_cnt <= '0;
                    if (req) begin
                        state <= S_SEND_WREN;
                    end
                end
                S_SEND_WREN: begin
                    if (frame_done) begin
                        state     <= S_GAP;
                        after_gap <= S_SEND_SE;
                        gap_cnt   <= '0;
                    end
                end
                S_SEND_SE: begin
                    if (frame_done) begin
                        state     <= S_GAP;
                        after_gap <= S_SEND_RDSR;
                        gap_cnt   <= '0;
                    end
                end
                S_SEND_RDSR: begin
                    if (frame_done) begin
                        state    <= S_CHECK_STATUS;
                        poll_cnt <= poll_cnt + 1'b1;
                    end
                end
                S_CHECK_STATUS: begin
                    if (!wip) begin
                        state      <= S_IDLE;
                        erase_done <= 1'b1;
                        finish     <= 1'b1;
                    end else if (poll_cnt == POLL_W'(MAX_POLLS)) begin
                        state      <= S_IDLE;  // Flash still busy, give up
                        erase_fail <= 1'b1;
                        finish     <= 1'b1;
                    end else begin
                        state     <= S_GAP;
                        after_gap <= S_SEND_RDSR;
                        gap_cnt   <= '0;
                    end
                end
                S_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_last) begin
                        state <= after_gap;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Frame contents stay put until the engine reports done
    always_ff @(posedge sys_clk) begin
        if (frame_launch) begin
            frame_word <= word_for(next_send, req_addr);
            frame_bits <= bits_for(next_send);
        end
    end

endmodule

`default_nettype wire

//--- source/spi_shift_engine.sv
`default_nettype none

module spi_shift_engine #(
    parameter int HALF_CYCLES = 5
) (
    input  logic                    sys_clk,
    input  logic                    sys_rst_n,
    input  logic                    frame_start,
    input  flash_pkg::frame_word_t  frame_word,
    input  flash_pkg::frame_bits_t  frame_bits,
    input  logic                    spi_miso,
    output logic                    spi_sck,
    output logic                    spi_cs_n,
    output logic                    spi_mosi,
    output logic                    frame_done,
    output flash_pkg::spi_byte_t    rx_byte
);

    localparam int DIV_W = (HALF_CYCLES > 1) ? $clog2(HALF_CYCLES) : 1;

    typedef enum logic [1:0] {
        E_IDLE,
        E_SHIFT,
        E_CLOSE,
        E_END
    } state_t;

    state_t                  state;
    logic [DIV_W-1:0]        div_cnt;   // Position inside one SCK half period
    flash_pkg::frame_bits_t  bit_cnt;
    flash_pkg::frame_word_t  shift_reg;
    logic                    half_end;
    logic                    last_bit;
    logic                    rise;
    logic                    fall;

    assign half_end = (div_cnt == DIV_W'(HALF_CYCLES - 1));
    assign last_bit = (flash_pkg::frame_bits_t'(bit_cnt + 1'b1) == frame_bits);
    assign rise     = (state == E_SHIFT) && half_end && !spi_sck;
    assign fall     = (state == E_SHIFT) && half_end && spi_sck;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state      <= E_IDLE;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            spi_sck    <= 1'b0;
            spi_cs_n   <= 1'b1;
            spi_mosi   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                E_IDLE: begin
                    if (frame_start) begin
                        state    <= E_SHIFT;
                        spi_cs_n <= 1'b0;
                        spi_sck  <= 1'b0;
                        spi_mosi <= frame_word[31];  // First bit with cs_n
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                    end
                end
                E_SHIFT: begin
                    if (half_end) begin
                        div_cnt <= '0;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                    if (rise) begin
                        spi_sck <= 1'b1;
                    end else if (fall) begin
                        spi_sck <= 1'b0;
                        if (last_bit) begin
                            state <= E_CLOSE;
                        end else begin
                            bit_cnt  <= bit_cnt + 1'b1;
                            spi_mosi <= shift_reg[30];  // Next bit after falling edge
                        end
                    end
                end
                E_CLOSE: begin
                    spi_cs_n <= 1'b1;
                    spi_mosi <= 1'b0;
                    state    <= E_END;
                end
                E_END: begin
                    frame_done <= 1'b1;
                    state      <= E_IDLE;
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    // Transmit and receive data paths
    always_ff @(posedge sys_clk) begin
        if ((state == E_IDLE) && frame_start) begin
            shift_reg <= frame_word;
        end else if (fall) begin
            shift_reg <= shift_reg << 1;
        end
        if (rise) begin
            rx_byte <= {rx_byte[6:0], spi_miso};  // Sample on rising SCK
        end
    end

endmodule

`default_nettype wire

//--- source/flash_erase_top.sv
`default_nettype none

module flash_erase_top #(
    parameter int HALF_CYCLES = 5,
    parameter int MAX_POLLS   = 200
) (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  logic                erase_start,
    input  flash_pkg::sector_t  sector,
    input  logic                spi_miso,
    output logic                busy,
    output logic                erase_done,
    output logic                erase_fail,
    output logic                spi_sck,
    output logic                spi_cs_n,
    output logic                spi_mosi
);

    logic                    req;
    flash_pkg::flash_addr_t  req_addr;
    logic                    finish;
    logic                    frame_start;
    flash_pkg::frame_word_t  frame_word;
    flash_pkg::frame_bits_t  frame_bits;
    logic                    frame_done;
    flash_pkg::spi_byte_t    rx_byte;

    erase_request_capture u_erase_request_capture (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .erase_start (erase_start),
        .sector      (sector),
        .finish      (finish),
        .busy        (busy),
        .req         (req),
        .req_addr    (req_addr)
    );

    erase_sequencer #(
        .HALF_CYCLES (HALF_CYCLES),
        .MAX_POLLS   (MAX_POLLS)
    ) u_erase_sequencer (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .req         (req),
        .req_addr    (req_addr),
        .frame_done  (frame_done),
        .rx_byte     (rx_byte),
        .frame_start (frame_start),
        .frame_word  (frame_word),
        .frame_bits  (frame_bits),
        .finish      (finish),
        .erase_done  (erase_done),
        .erase_fail  (erase_fail)
    );

    // SPI mode 0 pins
    spi_shift_engine #(
        .HALF_CYCLES (HALF_CYCLES)
    ) u_spi_shift_engine (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .frame_start (frame_start),
        .frame_word  (frame_word),
        .frame_bits  (frame_bits),
        .spi_miso    (spi_miso),
        .spi_sck     (spi_sck),
        .spi_cs_n    (spi_cs_n),
        .spi_mosi    (spi_mosi),
        .frame_done  (frame_done),
        .rx_byte     (rx_byte)
    );

endmodule

`default_nettype wire

//--- dv/spi_flash_model.sv
`default_nettype none

module spi_flash_model (
    input  logic        sys_clk,
    input  logic        spi_sck,
    input  logic        spi_cs_n,
    input  logic        spi_mosi,
    input  logic [7:0]  busy_polls,   // WIP stays set for this many RDSR frames after SE
    output logic        spi_miso
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LOG_DEPTH = 1024;

    flash_pkg::spi_byte_t    op_log [LOG_DEPTH];
    flash_pkg::flash_addr_t  addr_log [LOG_DEPTH];
    int                      log_len = 0;
    logic                    sck_q = 1'b0;
    logic                    cs_q = 1'b1;
    logic                    miso_q = 1'b0;
    logic [31:0]             rx_word = '0;
    int                      bit_cnt = 0;
    flash_pkg::spi_byte_t    cmd = '0;
    logic                    wel = 1'b0;
    int                      polls_left = 0;
    flash_pkg::spi_byte_t    status;

    assign spi_miso = miso_q;
    assign status   = {6'b000000, wel, (polls_left != 0)};

    // Pins sampled on the system clock, edges found against last cycle
    always @(posedge sys_clk) begin
        sck_q <= spi_sck;
        cs_q  <= spi_cs_n;
        if (!spi_cs_n && spi_sck && !sck_q) begin
            rx_word <= {rx_word[30:0], spi_mosi};
            bit_cnt <= bit_cnt + 1;
            if (bit_cnt == 7) begin
                cmd <= {rx_word[6:0], spi_mosi};  // Opcode complete
            end
        end
        if (!spi_cs_n && !spi_sck && sck_q && (cmd == flash_pkg::CMD_RDSR)
                && (bit_cnt >= 8) && (bit_cnt < 16)) begin
            miso_q <= status[15 - bit_cnt];  // Status byte MSB first
        end
        if (spi_cs_n) begin
            bit_cnt <= 0;
            miso_q  <= 1'b0;
        end
        if (spi_cs_n && !cs_q) begin
            if (log_len < LOG_DEPTH) begin
                op_log[log_len]   <= cmd;
                addr_log[log_len] <= (bit_cnt == 32) ? rx_word[23:0] : 24'h000000;
                log_len           <= log_len + 1;
            end
            if ((cmd == flash_pkg::CMD_WREN) && (bit_cnt == 8)) begin
                wel <= 1'b1;
            end else if ((cmd == flash_pkg::CMD_SE) && (bit_cnt == 32) && wel) begin
                wel        <= 1'b0;
                polls_left <= busy_polls;
            end else if ((cmd == flash_pkg::CMD_RDSR) && (polls_left != 0)) begin
                polls_left <= polls_left - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/flash_erase_sva.sv
`default_nettype none

module flash_erase_sva (
    input logic sys_clk,
    input logic sys_rst_n,
    input logic spi_sck,
    input logic spi_cs_n,
    input logic spi_mosi,
    input logic busy,
    input logic erase_done,
    input logic erase_fail
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    a_sck_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        spi_cs_n |-> !spi_sck)
        else begin
            fail_count++;
            $error("SCK high with chip select released");
        end

    a_mosi_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        spi_sck |-> $stable(spi_mosi))
        else begin
            fail_count++;
            $error("MOSI changed while SCK high");
        end

    a_not_both: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        !(erase_done && erase_fail))
        else begin
            fail_count++;
            $error("Done and fail raised together");
        end

    a_done_width: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        erase_done |=> !erase_done)
        else begin
            fail_count++;
            $error("Done pulse wider than one cycle");
        end

    a_fail_width: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        erase_fail |=> !erase_fail)
        else begin
            fail_count++;
            $error("Fail pulse wider than one cycle");
        end

    a_busy_falls: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (erase_done || erase_fail) |=> !busy)
        else begin
            fail_count++;
            $error("Busy still high after the end pulse");
        end

endmodule

`default_nettype wire

//--- dv/flash_erase_tb.sv
`default_nettype none

module flash_erase_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_CYCLES = 2;
    localparam int MAX_POLLS   = 24;
    localparam int NUM_ERASES  = 30;
    localparam int TIMEOUT     = 5000;  // Cycles per wait

    logic                sys_clk = 1'b0;
    logic                sys_rst_n = 1'b0;
    logic                erase_start = 1'b0;
    flash_pkg::sector_t  sector = '0;
    logic [7:0]          busy_polls = '0;
    logic                spi_miso;
    logic                busy;
    logic                erase_done;
    logic                erase_fail;
    logic                spi_sck;
    logic                spi_cs_n;
    logic                spi_mosi;
    integer              seed = 32'hc685b3b6;
    int                  done_seen = 0;
    int                  fail_seen = 0;

    flash_erase_top #(
        .HALF_CYCLES (HALF_CYCLES),
        .MAX_POLLS   (MAX_POLLS)
    ) u_flash_erase_top (.*);

    spi_flash_model u_flash (
        .sys_clk    (sys_clk),
        .spi_sck    (spi_sck),
        .spi_cs_n   (spi_cs_n),
        .spi_mosi   (spi_mosi),
        .busy_polls (busy_polls),
        .spi_miso   (spi_miso)
    );

    bind flash_erase_top flash_erase_sva u_sva (.*);

    initial begin
        forever #2 sys_clk = ~sys_clk;
    end

    // Running totals of end pulses
    always @(posedge sys_clk) begin
        if (erase_done) done_seen <= done_seen + 1;
        if (erase_fail) fail_seen <= fail_seen + 1;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic wait_busy(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (busy !== level) begin
            @(posedge sys_clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timed out after %0d cycles waiting for %s", TIMEOUT, what);
                $display("Checks failed");
                $fatal(1, "Wait timeout");
            end
        end
    endtask

    task automatic check_idle_pins();
        compare("spi_cs_n", spi_cs_n, 1'b1);
        compare("spi_sck", spi_sck, 1'b0);
        compare("spi_mosi", spi_mosi, 1'b0);
        compare("busy", busy, 1'b0);
        compare("erase_done", erase_done, 1'b0);
        compare("erase_fail", erase_fail, 1'b0);
    endtask

    task automatic run_erase(input flash_pkg::sector_t sec, input logic [7:0] polls);
        int base;
        int done0;
        int fail0;
        int exp_rdsr;
        flash_pkg::sector_t other;
        flash_pkg::flash_addr_t exp_addr;
        base     = u_flash.log_len;
        done0    = done_seen;
        fail0    = fail_seen;
        exp_rdsr = (polls < MAX_POLLS) ? polls + 1 : MAX_POLLS;
        exp_addr = '0;
        exp_addr[flash_pkg::SECTOR_SHIFT +: $bits(flash_pkg::sector_t)] = sec;  // 64 KiB sectors
        busy_polls  <= polls;
        sector      <= sec;
        erase_start <= 1'b1;
        @(posedge sys_clk);
        erase_start <= 1'b0;
        wait_busy(1'b1, "busy to rise");
        repeat (2) begin
            repeat (1 + {$random(seed)} % 40) @(posedge sys_clk);
            other = sec + 8'd1 + 8'({$random(seed)} % 255);  // Never the same sector
            if (busy) begin
                sector      <= other;
                erase_start <= 1'b1;
                @(posedge sys_clk);
                erase_start <= 1'b0;
            end
        end
        wait_busy(1'b0, "busy to fall");
        compare("frame count", u_flash.log_len - base, exp_rdsr + 2);
        compare("first opcode", u_flash.op_log[base], flash_pkg::CMD_WREN);
        compare("second opcode", u_flash.op_log[base + 1], flash_pkg::CMD_SE);
        compare("se address", u_flash.addr_log[base + 1], exp_addr);
        for (int i = 2; i < exp_rdsr + 2; i++) begin
            compare("poll opcode", u_flash.op_log[base + i], flash_pkg::CMD_RDSR);
        end
        compare("erase_done pulses", done_seen - done0, (polls < MAX_POLLS) ? 1 : 0);
        compare("erase_fail pulses", fail_seen - fail0, (polls < MAX_POLLS) ? 0 : 1);
    endtask

    initial begin
        flash_pkg::sector_t sec;
        logic [7:0]         polls;
        @(posedge sys_clk);  // First edge loads the reset values
        repeat (7) begin
            @(posedge sys_clk);
            check_idle_pins();
        end
        sys_rst_n <= 1'b1;
        repeat (2) begin
            @(posedge sys_clk);
            check_idle_pins();
        end
        for (int n = 0; n < NUM_ERASES; n++) begin
            sec = 8'($random(seed));
            if ((n % 8 == 5) || ({$random(seed)} % 10 == 0)) begin
                polls = 8'(MAX_POLLS + {$random(seed)} % 5);  // Flash never finishes in time
            end else begin
                polls = 8'({$random(seed)} % 21);
            end
            run_erase(sec, polls);
            @(posedge sys_clk);
        end
        compare("assertion failures", u_flash_erase_top.u_sva.fail_count, 0);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
source/flash_pkg.sv
source/erase_request_capture.sv
source/erase_sequencer.sv
source/spi_shift_engine.sv
source/flash_erase_top.sv
dv/spi_flash_model.sv
dv/flash_erase_sva.sv
dv/flash_erase_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module flash_erase_tb \
    -f files.f -o flash_erase_sim || exit 1
out="$(./obj_dir/flash_erase_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "All checks passed" && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
